// ==== compile.f ====
pcs_rx_pkg.sv
rx_block_typer.sv
rx_sequence_fsm.sv
pcs_rx_decode_top.sv
tb_pcs_rx_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pcs_rx_decode
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_pcs_rx_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_pcs_rx_decode;

	typedef struct packed
	{
		pcs_rx_pkg::rx_block_t  blk;
		logic                   frame_end;
		pcs_rx_pkg::err_count_t count;	// counter value after this block
	} expect_t;

	logic                   i_clock;
	logic                   i_reset;
	logic                   i_enable;
	logic                   i_valid;
	pcs_rx_pkg::rx_block_t  i_block;
	logic                   o_valid;
	pcs_rx_pkg::rx_block_t  o_block;
	logic                   o_frame_end;
	pcs_rx_pkg::err_count_t o_error_count;

	int seed = 44427;
	expect_t expect_q[$];
	expect_t exp_head;
	pcs_rx_pkg::rx_state_e   model_state;
	pcs_rx_pkg::rx_block_t   model_held;
	pcs_rx_pkg::block_type_e model_held_type;
	logic                    model_full;
	pcs_rx_pkg::err_count_t  exp_count;

	pcs_rx_decode_top dut
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_valid       (i_valid),
		.i_block       (i_block),
		.o_valid       (o_valid),
		.o_block       (o_block),
		.o_frame_end   (o_frame_end),
		.o_error_count (o_error_count)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [71:0] exp_v,
		input logic [71:0] got_v);
		fail_run($sformatf("[ERROR] %s expected %h got %h", name, exp_v, got_v));
	endtask

	function automatic pcs_rx_pkg::block_type_e block_class(input pcs_rx_pkg::rx_block_t blk);
		logic [7:0] lane [8];
		logic       upper_idle;
		for (int i = 0; i < 8; i++)
			lane[i] = blk.data[8*i +: 8];
		if (blk.ctrl == 8'h00)
			return pcs_rx_pkg::TYPE_D;
		if (blk.ctrl == 8'h01 && lane[0] == 8'hFB)
			return pcs_rx_pkg::TYPE_S;
		if (blk.ctrl == 8'hFF && blk.data == {8{8'h07}})
			return pcs_rx_pkg::TYPE_C;
		for (int k = 0; k < 8; k++)
		begin
			upper_idle = 1'b1;
			for (int j = k + 1; j < 8; j++)
				upper_idle = upper_idle && (lane[j] == 8'h07);
			if (blk.ctrl == 8'(8'hFF << k) && lane[k] == 8'hFD && upper_idle)
				return pcs_rx_pkg::TYPE_T;
		end
		return pcs_rx_pkg::TYPE_E;
	endfunction

	// transition table of the receive sequence
	function automatic pcs_rx_pkg::rx_state_e model_next(input pcs_rx_pkg::rx_state_e st,
		input pcs_rx_pkg::block_type_e t, input pcs_rx_pkg::block_type_e tn);
		logic term_ok;
		term_ok = (t == pcs_rx_pkg::TYPE_T)
			&& (tn == pcs_rx_pkg::TYPE_S || tn == pcs_rx_pkg::TYPE_C);
		if (st == pcs_rx_pkg::RX_D)
		begin
			if (t == pcs_rx_pkg::TYPE_D)
				return pcs_rx_pkg::RX_D;
			return term_ok ? pcs_rx_pkg::RX_T : pcs_rx_pkg::RX_E;
		end
		if (t == pcs_rx_pkg::TYPE_C)
			return pcs_rx_pkg::RX_C;
		if (t == pcs_rx_pkg::TYPE_S)
			return pcs_rx_pkg::RX_D;
		if (st == pcs_rx_pkg::RX_E && term_ok)
			return pcs_rx_pkg::RX_T;
		return pcs_rx_pkg::RX_E;
	endfunction

	// judge the held block against the new one, then hold the new one
	task automatic model_accept(input pcs_rx_pkg::rx_block_t blk);
		pcs_rx_pkg::block_type_e t_in;
		pcs_rx_pkg::rx_state_e   ns;
		expect_t                 e;
		t_in = block_class(blk);
		if (model_full)
		begin
			ns = model_next(model_state, model_held_type, t_in);
			e.frame_end = (ns == pcs_rx_pkg::RX_T);
			e.blk = model_held;
			if (ns == pcs_rx_pkg::RX_E)
			begin
				e.blk.data = {8{8'h1E}};
				e.blk.ctrl = 8'hFF;
				exp_count = exp_count + 32'd1;
			end
			e.count = exp_count;
			expect_q.push_back(e);
			model_state = ns;
		end
		model_held = blk;
		model_held_type = t_in;
		model_full = 1'b1;
	endtask

	function automatic pcs_rx_pkg::block_data_t rand_data();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic pcs_rx_pkg::rx_block_t make_data();
		return '{data: rand_data(), ctrl: 8'h00};
	endfunction

	function automatic pcs_rx_pkg::rx_block_t make_start();
		pcs_rx_pkg::rx_block_t blk;
		blk.data = rand_data();
		blk.data[7:0] = 8'hFB;
		blk.ctrl = 8'h01;
		return blk;
	endfunction

	function automatic pcs_rx_pkg::rx_block_t make_idle();
		return '{data: {8{8'h07}}, ctrl: 8'hFF};
	endfunction

	function automatic pcs_rx_pkg::rx_block_t make_term(input int k);
		pcs_rx_pkg::rx_block_t blk;
		blk.data = rand_data();	// lanes below k keep payload
		for (int i = k; i < 8; i++)
			blk.data[8*i +: 8] = (i == k) ? 8'hFD : 8'h07;
		blk.ctrl = 8'(8'hFF << k);
		return blk;
	endfunction

	function automatic pcs_rx_pkg::rx_block_t make_corrupt();
		pcs_rx_pkg::rx_block_t blk;
		blk = make_idle();
		blk.data[31:24] = 8'h55;	// bad byte in an idle block
		return blk;
	endfunction

	function automatic pcs_rx_pkg::rx_block_t random_block();
		int            pick;
		logic [71:0]   flip;
		pick = int'($unsigned($random(seed)) % 10);
		case (pick)
			0, 1:    return make_idle();
			2:       return make_start();
			3, 4, 5: return make_data();
			6, 7:    return make_term(int'($unsigned($random(seed)) % 8));
			default:
			begin
				flip = 72'(1) << ($unsigned($random(seed)) % 72);
				return make_term(int'($unsigned($random(seed)) % 8)) ^ flip;
			end
		endcase
	endfunction

	task automatic check_quiet();
		assert (o_valid === 1'b0) else report_mismatch("o_valid", 72'(0), 72'(o_valid));
		assert (o_frame_end === 1'b0)
			else report_mismatch("o_frame_end", 72'(0), 72'(o_frame_end));
		assert (o_error_count === exp_count)
			else report_mismatch("o_error_count", 72'(exp_count), 72'(o_error_count));
	endtask

	task automatic send_block(input pcs_rx_pkg::rx_block_t blk);
		i_enable = 1'b1;
		i_valid = 1'b1;
		i_block = blk;
		model_accept(blk);
		@(posedge i_clock);
		#1;
	endtask

	// en and vld never both high here
	task automatic gap_cycles(input int n, input logic en, input logic vld);
		for (int i = 0; i < n; i++)
		begin
			i_enable = en;
			i_valid = vld;
			i_block = make_data();
			@(posedge i_clock);
			#1;
			check_quiet();
		end
	endtask

	task automatic wait_drain(input int limit);
		int cycles;
		cycles = 0;
		while (expect_q.size() != 0)
		begin
			if (cycles >= limit)
				fail_run("timed out waiting for expected output blocks");
			@(posedge i_clock);
			#1;
			cycles++;
		end
	endtask

	always @(negedge i_clock)
	begin
		if (!i_reset && o_valid === 1'b1)
		begin
			if (expect_q.size() == 0)
				fail_run("o_valid pulsed while no output block was expected");
			exp_head = expect_q.pop_front();
			assert (o_block === exp_head.blk)
				else report_mismatch("o_block", exp_head.blk, o_block);
			assert (o_frame_end === exp_head.frame_end)
				else report_mismatch("o_frame_end", 72'(exp_head.frame_end), 72'(o_frame_end));
			assert (o_error_count === exp_head.count)
				else report_mismatch("o_error_count", 72'(exp_head.count), 72'(o_error_count));
		end
	end

	initial
	begin
		i_reset = 1'b1;
		i_enable = 1'b0;
		i_valid = 1'b0;
		i_block = '0;
		model_state = pcs_rx_pkg::RX_INIT;
		model_held = '0;
		model_held_type = pcs_rx_pkg::TYPE_E;
		model_full = 1'b0;
		exp_count = '0;
		repeat (2) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		gap_cycles(5, 1'b0, 1'b0);	// quiet after reset

		// legal frames with every terminate lane
		send_block(make_idle());
		for (int k = 0; k < 8; k++)
		begin
			send_block(make_start());
			send_block(make_data());
			send_block(make_data());
			send_block(make_term(k));
			if (k % 2 == 0)
				send_block(make_idle());	// odd k runs straight into the next start
		end
		send_block(make_idle());

		// illegal sequences
		send_block(make_data());	// D after C
		send_block(make_idle());
		send_block(make_term(2));	// T after C
		send_block(make_idle());
		send_block(make_start());
		send_block(make_start());	// S inside a frame
		send_block(make_idle());
		send_block(make_start());
		send_block(make_data());
		send_block(make_idle());	// C inside a frame
		send_block(make_idle());
		send_block(make_corrupt());
		send_block(make_idle());
		send_block(make_start());
		send_block(make_data());
		send_block(make_term(3));
		send_block(make_data());	// T followed by D

		// recovery, late terminate from the error state
		send_block(make_corrupt());
		send_block(make_term(4));
		send_block(make_start());
		send_block(make_data());
		send_block(make_term(0));
		send_block(make_idle());

		// stalls in the middle of a frame
		send_block(make_start());
		gap_cycles(4, 1'b0, 1'b1);
		send_block(make_data());
		gap_cycles(4, 1'b1, 1'b0);
		send_block(make_term(6));
		gap_cycles(3, 1'b0, 1'b0);
		send_block(make_idle());

		for (int n = 0; n < 2000; n++)
		begin
			if ($unsigned($random(seed)) % 4 == 0)
				gap_cycles(1 + int'($unsigned($random(seed)) % 3),
					1'($random(seed)), 1'b0);
			send_block(random_block());
		end
		send_block(make_idle());
		gap_cycles(2, 1'b0, 1'b0);
		wait_drain(50);

		if (o_error_count !== exp_count)
			report_mismatch("o_error_count", 72'(exp_count), 72'(o_error_count));
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== pcs_rx_decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pcs_rx_decode_top
(
	input  wire                        i_clock,
	input  wire                        i_reset,
	input  wire                        i_enable,
	input  wire                        i_valid,
	input  wire pcs_rx_pkg::rx_block_t i_block,
	output logic                       o_valid,
	output pcs_rx_pkg::rx_block_t      o_block,
	output logic                       o_frame_end,
	output pcs_rx_pkg::err_count_t     o_error_count
);

	logic                    blk_valid;
	pcs_rx_pkg::rx_block_t   held_block;	// block under judgement
	pcs_rx_pkg::block_type_e held_type;
	pcs_rx_pkg::block_type_e type_next;	// class of the block behind it

	rx_block_typer u_typer
	(
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_enable    (i_enable),
		.i_valid     (i_valid),
		.i_block     (i_block),
		.o_blk_valid (blk_valid),
		.o_block     (held_block),
		.o_type      (held_type),
		.o_type_next (type_next)
	);

	rx_sequence_fsm u_fsm
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_blk_valid   (blk_valid),
		.i_block       (held_block),
		.i_type        (held_type),
		.i_type_next   (type_next),
		.o_valid       (o_valid),
		.o_frame_end   (o_frame_end),
		.o_block       (o_block),
		.o_error_count (o_error_count)
	);

endmodule

`default_nettype wire

// ==== rx_sequence_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_sequence_fsm
(
	input  wire                         i_clock,
	input  wire                         i_reset,
	input  wire                         i_blk_valid,
	input  wire pcs_rx_pkg::rx_block_t  i_block,
	input  wire pcs_rx_pkg::block_type_e i_type,
	input  wire pcs_rx_pkg::block_type_e i_type_next,
	output logic                        o_valid,
	output logic                        o_frame_end,
	output pcs_rx_pkg::rx_block_t       o_block,
	output pcs_rx_pkg::err_count_t      o_error_count
);

	pcs_rx_pkg::rx_state_e state;
	pcs_rx_pkg::rx_state_e state_next;
	pcs_rx_pkg::rx_block_t block_next;
	logic next_is_gap;	// block after the held one opens a gap or a frame
	logic term_ok;

	assign next_is_gap = (i_type_next == pcs_rx_pkg::TYPE_S)
		|| (i_type_next == pcs_rx_pkg::TYPE_C);
	assign term_ok = (i_type == pcs_rx_pkg::TYPE_T) && next_is_gap;

	// next state from the held block type
	always_comb
	begin
		state_next = pcs_rx_pkg::RX_E;
		case (state)
			pcs_rx_pkg::RX_D:
			begin
				if (i_type == pcs_rx_pkg::TYPE_D)
					state_next = pcs_rx_pkg::RX_D;
				else if (term_ok)
					state_next = pcs_rx_pkg::RX_T;
			end

			pcs_rx_pkg::RX_E:
			begin
				if (i_type == pcs_rx_pkg::TYPE_C)
					state_next = pcs_rx_pkg::RX_C;
				else if (i_type == pcs_rx_pkg::TYPE_S)
					state_next = pcs_rx_pkg::RX_D;
				else if (term_ok)
					state_next = pcs_rx_pkg::RX_T;	// late terminate still ends a frame
			end

			default:	// init, idle and terminate behave the same
			begin
				if (i_type == pcs_rx_pkg::TYPE_C)
					state_next = pcs_rx_pkg::RX_C;
				else if (i_type == pcs_rx_pkg::TYPE_S)
					state_next = pcs_rx_pkg::RX_D;
			end
		endcase
	end

	// legal blocks pass, illegal ones become the error block
	always_comb
	begin
		if (state_next == pcs_rx_pkg::RX_E)
		begin
			block_next.data = pcs_rx_pkg::EBLOCK_DATA;
			block_next.ctrl = pcs_rx_pkg::EBLOCK_CTRL;
		end
		else
		begin
			block_next = i_block;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			state <= pcs_rx_pkg::RX_INIT;
		else if (i_blk_valid)
			state <= state_next;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_valid     <= 1'b0;
			o_frame_end <= 1'b0;
			o_block     <= '0;
		end
		else
		begin
			o_valid     <= i_blk_valid;	// one pulse per judged block
			o_frame_end <= i_blk_valid && (state_next == pcs_rx_pkg::RX_T);
			if (i_blk_valid)
				o_block <= block_next;
		end
	end

	// one count per replaced block
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_error_count <= '0;
		else if (i_blk_valid && state_next == pcs_rx_pkg::RX_E)
			o_error_count <= o_error_count + pcs_rx_pkg::err_count_t'(1);
	end

endmodule

`default_nettype wire

// ==== rx_block_typer.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_block_typer
(
	input  wire                     i_clock,
	input  wire                     i_reset,
	input  wire                     i_enable,
	input  wire                     i_valid,
	input  wire pcs_rx_pkg::rx_block_t i_block,
	output logic                    o_blk_valid,
	output pcs_rx_pkg::rx_block_t   o_block,
	output pcs_rx_pkg::block_type_e o_type,
	output pcs_rx_pkg::block_type_e o_type_next
);

	logic accept;
	logic full;	// holder carries a block
	pcs_rx_pkg::block_type_e type_in;

	// terminate in lane k with idles in every lane above it
	function automatic logic is_term_block(input pcs_rx_pkg::rx_block_t blk);
		pcs_rx_pkg::block_ctrl_t term_mask;
		logic idle_above;
		logic found;
		found = 1'b0;
		for (int k = 0; k < pcs_rx_pkg::CTRL_W; k++)
		begin
			term_mask = {pcs_rx_pkg::CTRL_W{1'b1}} << k;
			idle_above = 1'b1;
			for (int j = k + 1; j < pcs_rx_pkg::CTRL_W; j++)
			begin
				if (blk.data[8*j +: 8] != pcs_rx_pkg::CODE_IDLE)
					idle_above = 1'b0;
			end
			if (blk.ctrl == term_mask && blk.data[8*k +: 8] == pcs_rx_pkg::CODE_TERM
				&& idle_above)
				found = 1'b1;
		end
		return found;
	endfunction

	// first match wins
	function automatic pcs_rx_pkg::block_type_e classify_block(
		input pcs_rx_pkg::rx_block_t blk);
		pcs_rx_pkg::block_type_e kind;
		if (blk.ctrl == '0)
			kind = pcs_rx_pkg::TYPE_D;
		else if (blk.ctrl == 8'h01 && blk.data[7:0] == pcs_rx_pkg::CODE_START)
			kind = pcs_rx_pkg::TYPE_S;
		else if (blk.ctrl == '1
			&& blk.data == {pcs_rx_pkg::CTRL_W{pcs_rx_pkg::CODE_IDLE}})
			kind = pcs_rx_pkg::TYPE_C;
		else if (is_term_block(blk))
			kind = pcs_rx_pkg::TYPE_T;
		else
			kind = pcs_rx_pkg::TYPE_E;
		return kind;
	endfunction

	assign accept  = i_enable && i_valid;
	assign type_in = classify_block(i_block);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			full <= 1'b0;
		else if (accept)
			full <= 1'b1;
	end

	// held block and its class, only meaningful while full
	always_ff @(posedge i_clock)
	begin
		if (accept)
		begin
			o_block <= i_block;
			o_type  <= type_in;
		end
	end

	assign o_type_next = type_in;	// lookahead for the held terminate
	assign o_blk_valid = accept && full;	// first block after reset only fills

endmodule

`default_nettype wire

// ==== pcs_rx_pkg.sv ====
`default_nettype none

package pcs_rx_pkg;

	// widths
	localparam int DATA_W  = 64;	// block payload
	localparam int CTRL_W  = 8;	// one control bit per byte
	localparam int COUNT_W = 32;	// replaced block counter

	typedef logic [DATA_W-1:0]  block_data_t;
	typedef logic [CTRL_W-1:0]  block_ctrl_t;
	typedef logic [COUNT_W-1:0] err_count_t;

	// control byte codes as seen after the decoder
	localparam logic [7:0] CODE_IDLE  = 8'h07;
	localparam logic [7:0] CODE_START = 8'hFB;
	localparam logic [7:0] CODE_TERM  = 8'hFD;
	localparam logic [7:0] CODE_ERROR = 8'h1E;

	// block sent in place of an illegal one
	localparam block_data_t EBLOCK_DATA = {CTRL_W{CODE_ERROR}};
	localparam block_ctrl_t EBLOCK_CTRL = {CTRL_W{1'b1}};	// every byte is control

	// block classes produced by the typer
	typedef enum logic [2:0]
	{
		TYPE_D,	// all data
		TYPE_S,	// start in lane 0
		TYPE_C,	// all idle
		TYPE_T,	// terminate in lane k, idle above
		TYPE_E	// anything else
	} block_type_e;

	// receive sequence states
	typedef enum logic [2:0]
	{
		RX_INIT,
		RX_C,	// between frames
		RX_D,	// inside a frame
		RX_T,	// frame just ended
		RX_E	// after an illegal block
	} rx_state_e;

	// byte k lives in data[8k+7:8k], its control bit is ctrl[k]
	typedef struct packed
	{
		block_data_t data;
		block_ctrl_t ctrl;
	} rx_block_t;

endpackage

`default_nettype wire
